/* hdl/mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Processor byte address and data word
`define ADDR_W 16
`define WORD_W 16

// Address split: tag [15:11], index [10:3], word offset [2:1], bit 0 zero
`define OFFSET_W 2
`define INDEX_W 8
`define TAG_W 5

// Cache geometry
`define LINES 256
`define WORDS 4

// Main memory, one bank per word of a line
`define BANKS 4
// Read latency, also the busy time of a bank after any access
`define MEM_LAT 3

`endif

/* hdl/mem_pkg.sv */
`include "mem_defines.svh"

package mem_pkg;

   // Controller states
   typedef enum logic [2:0] {
      IDLE,
      COMPARE,
      WRITE_BACK,
      FILL,
      MERGE,
      RESPOND
   } ctrl_state_t;

   // Address fields
   typedef logic [`TAG_W-1:0] tag_t;
   typedef logic [`INDEX_W-1:0] index_t;
   typedef logic [`OFFSET_W-1:0] offset_t;

   // One data word
   typedef logic [`WORD_W-1:0] word_t;

endpackage

/* hdl/cache_array.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module cache_array (
   input  logic clk,
   input  logic rst,
   input  logic arr_en,
   input  logic arr_write,
   input  mem_pkg::index_t arr_index,
   input  mem_pkg::offset_t arr_offset,
   input  mem_pkg::word_t arr_wdata,
   input  logic arr_tag_wr,
   input  mem_pkg::tag_t arr_wtag,
   input  logic arr_set_dirty,
   input  logic arr_clr_dirty,
   output mem_pkg::tag_t rd_tag,
   output logic rd_valid,
   output logic rd_dirty,
   output mem_pkg::word_t rd_word,
   output mem_pkg::word_t [`WORDS-1:0] rd_line
);

   // Per-line state
   mem_pkg::tag_t tag_mem [`LINES];
   logic [`LINES-1:0] valid_bits;
   logic [`LINES-1:0] dirty_bits;

   // Line data, one word per bank slot
   mem_pkg::word_t data_mem [`LINES][`WORDS];

   // Valid bits are the only state cleared by reset
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_bits <= '0;
      end else if (arr_en && arr_tag_wr) begin
         valid_bits[arr_index] <= 1'b1;
      end
   end

   // Tag install
   always_ff @(posedge clk) begin
      if (arr_en && arr_tag_wr) begin
         tag_mem[arr_index] <= arr_wtag;
      end
   end

   // Dirty flag, set wins over clear
   always_ff @(posedge clk) begin
      if (arr_en) begin
         if (arr_set_dirty) begin
            dirty_bits[arr_index] <= 1'b1;
         end else if (arr_clr_dirty) begin
            dirty_bits[arr_index] <= 1'b0;
         end
      end
   end

   // Single word write
   always_ff @(posedge clk) begin
      if (arr_en && arr_write) begin
         data_mem[arr_index][arr_offset] <= arr_wdata;
      end
   end

   // Registered read port
   // Returns the contents before any write in the same cycle
   // Outputs hold while arr_en is low, so the line stays put for write-back
   always_ff @(posedge clk) begin
      if (arr_en) begin
         rd_tag   <= tag_mem[arr_index];
         rd_valid <= valid_bits[arr_index];
         rd_dirty <= dirty_bits[arr_index];
         rd_word  <= data_mem[arr_index][arr_offset];
         for (int w = 0; w < `WORDS; w++) begin
            rd_line[w] <= data_mem[arr_index][w];
         end
      end
   end

endmodule

/* hdl/banked_mem.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module banked_mem (
   input  logic clk,
   input  logic rst,
   input  logic mem_rd,
   input  logic mem_wr,
   input  logic [`ADDR_W-1:0] mem_addr,
   input  mem_pkg::word_t mem_wdata,
   output logic mem_stall,
   output logic mem_rvalid,
   output mem_pkg::word_t mem_rdata
);

   // Row address inside a bank, above the bank select and byte bit
   localparam int ROW_W = `ADDR_W - `OFFSET_W - 1;
   localparam int CNT_W = $clog2(`MEM_LAT + 1);

   logic [`OFFSET_W-1:0] bank_sel;
   logic [ROW_W-1:0] row;
   logic take;

   // Storage and busy timers
   mem_pkg::word_t store [`BANKS][2**ROW_W];
   logic [CNT_W-1:0] busy_cnt [`BANKS];

   // Read return pipeline
   logic [`MEM_LAT-1:0] pipe_vld;
   mem_pkg::word_t pipe_dat [`MEM_LAT];

   assign bank_sel = mem_addr[1 +: `OFFSET_W];
   assign row      = mem_addr[`ADDR_W-1 -: ROW_W];

   // Stall while the addressed bank is still counting down
   assign mem_stall = (mem_rd || mem_wr) && (busy_cnt[bank_sel] != '0);
   assign take      = (mem_rd || mem_wr) && !mem_stall;

   // Memory comes up all zero
   initial begin
      for (int b = 0; b < `BANKS; b++) begin
         for (int r = 0; r < 2**ROW_W; r++) begin
            store[b][r] = '0;
         end
      end
   end

   // Writes land at once
   always @(posedge clk) begin
      if (take && mem_wr) begin
         store[bank_sel][row] <= mem_wdata;
      end
   end

   // Per-bank countdown, reloaded on every accepted access
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < `BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < `BANKS; b++) begin
            if (take && (bank_sel == b[`OFFSET_W-1:0])) begin
               busy_cnt[b] <= CNT_W'(`MEM_LAT);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // Valid flags of reads in flight
   always_ff @(posedge clk) begin
      if (rst) begin
         pipe_vld <= '0;
      end else begin
         pipe_vld[0] <= take && mem_rd;
         for (int i = 1; i < `MEM_LAT; i++) begin
            pipe_vld[i] <= pipe_vld[i-1];
         end
      end
   end

   // Data follows its flag down the pipe
   always_ff @(posedge clk) begin
      pipe_dat[0] <= store[bank_sel][row];
      for (int i = 1; i < `MEM_LAT; i++) begin
         pipe_dat[i] <= pipe_dat[i-1];
      end
   end

   assign mem_rvalid = pipe_vld[`MEM_LAT-1];
   assign mem_rdata  = pipe_dat[`MEM_LAT-1];

endmodule

/* hdl/cache_ctrl.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module cache_ctrl (
   input  logic clk,
   input  logic rst,
   // Processor side
   input  logic rd,
   input  logic wr,
   input  logic [`ADDR_W-1:0] addr,
   input  mem_pkg::word_t data_in,
   output mem_pkg::word_t data_out,
   output logic done,
   output logic hit,
   output logic busy,
   output logic err,
   // Cache array control
   output logic arr_en,
   output logic arr_write,
   output mem_pkg::index_t arr_index,
   output mem_pkg::offset_t arr_offset,
   output mem_pkg::word_t arr_wdata,
   output logic arr_tag_wr,
   output mem_pkg::tag_t arr_wtag,
   output logic arr_set_dirty,
   output logic arr_clr_dirty,
   // Cache array returns
   input  mem_pkg::tag_t rd_tag,
   input  logic rd_valid,
   input  logic rd_dirty,
   input  mem_pkg::word_t rd_word,
   input  mem_pkg::word_t [`WORDS-1:0] rd_line,
   // Main memory
   output logic mem_rd,
   output logic mem_wr,
   output logic [`ADDR_W-1:0] mem_addr,
   output mem_pkg::word_t mem_wdata,
   input  logic mem_stall,
   input  logic mem_rvalid,
   input  mem_pkg::word_t mem_rdata
);

   mem_pkg::ctrl_state_t state;
   mem_pkg::ctrl_state_t next_state;

   // Latched request
   logic req_wr;
   mem_pkg::tag_t req_tag;
   mem_pkg::index_t req_index;
   mem_pkg::offset_t req_offset;
   mem_pkg::word_t req_data;

   // Word counters: issued transfers and fill returns
   logic [`OFFSET_W:0] wcnt;
   mem_pkg::offset_t wsel;
   mem_pkg::offset_t rcnt;

   logic req_ok;
   logic req_bad;
   logic tag_match;
   logic xfer;
   logic hit_q;
   logic err_q;
   mem_pkg::word_t data_q;

   // Exactly one strobe on an even address
   assign req_ok  = (rd ^ wr) && !addr[0];
   assign req_bad = (rd || wr) && ((rd && wr) || addr[0]);

   assign tag_match = rd_valid && (rd_tag == req_tag);
   assign wsel      = wcnt[`OFFSET_W-1:0];
   // Memory took the transfer this cycle
   assign xfer      = (mem_rd || mem_wr) && !mem_stall;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= mem_pkg::IDLE;
         wcnt  <= '0;
         rcnt  <= '0;
         hit_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         state <= next_state;
         // Rejected strobes only flag err, and only when idle
         err_q <= (state == mem_pkg::IDLE) && req_bad;
         if (state == mem_pkg::COMPARE) begin
            hit_q <= tag_match;
            wcnt  <= '0;
            rcnt  <= '0;
         end
         if (state == mem_pkg::WRITE_BACK && xfer) begin
            // Restart the count for the fill reads
            wcnt <= (wcnt == `WORDS - 1) ? '0 : wcnt + 1'b1;
         end
         if (state == mem_pkg::FILL) begin
            if (xfer) begin
               wcnt <= wcnt + 1'b1;
            end
            if (mem_rvalid) begin
               rcnt <= rcnt + 1'b1;
            end
         end
      end
   end

   // Request payload
   always_ff @(posedge clk) begin
      if (state == mem_pkg::IDLE && req_ok) begin
         req_wr     <= wr;
         req_tag    <= addr[`ADDR_W-1 -: `TAG_W];
         req_index  <= addr[`OFFSET_W+1 +: `INDEX_W];
         req_offset <= addr[1 +: `OFFSET_W];
         req_data   <= data_in;
      end
   end

   // Keep the requested word as it comes back from memory
   always_ff @(posedge clk) begin
      if (state == mem_pkg::FILL && mem_rvalid && rcnt == req_offset) begin
         data_q <= mem_rdata;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         mem_pkg::IDLE: begin
            if (req_ok) begin
               next_state = mem_pkg::COMPARE;
            end
         end
         mem_pkg::COMPARE: begin
            if (tag_match) begin
               next_state = mem_pkg::IDLE;
            end else if (rd_valid && rd_dirty) begin
               next_state = mem_pkg::WRITE_BACK;
            end else begin
               next_state = mem_pkg::FILL;
            end
         end
         mem_pkg::WRITE_BACK: begin
            if (xfer && wcnt == `WORDS - 1) begin
               next_state = mem_pkg::FILL;
            end
         end
         mem_pkg::FILL: begin
            // Last return installed, writes still owe the merge
            if (mem_rvalid && rcnt == `WORDS - 1) begin
               next_state = req_wr ? mem_pkg::MERGE : mem_pkg::RESPOND;
            end
         end
         mem_pkg::MERGE: next_state = mem_pkg::RESPOND;
         mem_pkg::RESPOND: next_state = mem_pkg::IDLE;
         default: next_state = mem_pkg::IDLE;
      endcase
   end

   always_comb begin
      arr_en        = 1'b0;
      arr_write     = 1'b0;
      arr_index     = req_index;
      arr_offset    = req_offset;
      arr_wdata     = req_data;
      arr_tag_wr    = 1'b0;
      arr_wtag      = req_tag;
      arr_set_dirty = 1'b0;
      arr_clr_dirty = 1'b0;
      mem_rd        = 1'b0;
      mem_wr        = 1'b0;
      mem_addr      = {req_tag, req_index, wsel, 1'b0};
      mem_wdata     = rd_line[wsel];
      case (state)
         mem_pkg::IDLE: begin
            // Look up straight from the strobe so a hit answers next cycle
            arr_en     = req_ok;
            arr_index  = addr[`OFFSET_W+1 +: `INDEX_W];
            arr_offset = addr[1 +: `OFFSET_W];
         end
         mem_pkg::COMPARE: begin
            if (tag_match && req_wr) begin
               arr_en        = 1'b1;
               arr_write     = 1'b1;
               arr_set_dirty = 1'b1;
            end
         end
         mem_pkg::WRITE_BACK: begin
            // Old line still sits on the array outputs
            mem_wr   = 1'b1;
            mem_addr = {rd_tag, req_index, wsel, 1'b0};
         end
         mem_pkg::FILL: begin
            mem_rd = !wcnt[`OFFSET_W];
            if (mem_rvalid) begin
               arr_en        = 1'b1;
               arr_write     = 1'b1;
               arr_offset    = rcnt;
               arr_wdata     = mem_rdata;
               arr_tag_wr    = 1'b1;
               arr_clr_dirty = 1'b1;
            end
         end
         mem_pkg::MERGE: begin
            arr_en        = 1'b1;
            arr_write     = 1'b1;
            arr_set_dirty = 1'b1;
         end
         default: begin
         end
      endcase
   end

   // Hits answer from COMPARE, misses from RESPOND
   assign busy     = (state != mem_pkg::IDLE);
   assign done     = ((state == mem_pkg::COMPARE) && tag_match) || (state == mem_pkg::RESPOND);
   assign hit      = (state == mem_pkg::COMPARE) ? tag_match : hit_q;
   assign data_out = (state == mem_pkg::COMPARE) ? rd_word : data_q;
   assign err      = err_q;

endmodule

/* hdl/mem_system.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_system (
   input  logic clk,
   input  logic rst,
   input  logic rd,
   input  logic wr,
   input  logic [`ADDR_W-1:0] addr,
   input  mem_pkg::word_t data_in,
   output mem_pkg::word_t data_out,
   output logic done,
   output logic hit,
   output logic busy,
   output logic err
);

   // Controller to cache array
   logic arr_en;
   logic arr_write;
   mem_pkg::index_t arr_index;
   mem_pkg::offset_t arr_offset;
   mem_pkg::word_t arr_wdata;
   logic arr_tag_wr;
   mem_pkg::tag_t arr_wtag;
   logic arr_set_dirty;
   logic arr_clr_dirty;

   // Cache array returns
   mem_pkg::tag_t rd_tag;
   logic rd_valid;
   logic rd_dirty;
   mem_pkg::word_t rd_word;
   mem_pkg::word_t [`WORDS-1:0] rd_line;

   // Controller to main memory
   logic mem_rd;
   logic mem_wr;
   logic [`ADDR_W-1:0] mem_addr;
   mem_pkg::word_t mem_wdata;
   logic mem_stall;
   logic mem_rvalid;
   mem_pkg::word_t mem_rdata;

   cache_ctrl i_ctrl (
      .clk           (clk),
      .rst           (rst),
      .rd            (rd),
      .wr            (wr),
      .addr          (addr),
      .data_in       (data_in),
      .data_out      (data_out),
      .done          (done),
      .hit           (hit),
      .busy          (busy),
      .err           (err),
      .arr_en        (arr_en),
      .arr_write     (arr_write),
      .arr_index     (arr_index),
      .arr_offset    (arr_offset),
      .arr_wdata     (arr_wdata),
      .arr_tag_wr    (arr_tag_wr),
      .arr_wtag      (arr_wtag),
      .arr_set_dirty (arr_set_dirty),
      .arr_clr_dirty (arr_clr_dirty),
      .rd_tag        (rd_tag),
      .rd_valid      (rd_valid),
      .rd_dirty      (rd_dirty),
      .rd_word       (rd_word),
      .rd_line       (rd_line),
      .mem_rd        (mem_rd),
      .mem_wr        (mem_wr),
      .mem_addr      (mem_addr),
      .mem_wdata     (mem_wdata),
      .mem_stall     (mem_stall),
      .mem_rvalid    (mem_rvalid),
      .mem_rdata     (mem_rdata)
   );

   cache_array i_array (
      .clk           (clk),
      .rst           (rst),
      .arr_en        (arr_en),
      .arr_write     (arr_write),
      .arr_index     (arr_index),
      .arr_offset    (arr_offset),
      .arr_wdata     (arr_wdata),
      .arr_tag_wr    (arr_tag_wr),
      .arr_wtag      (arr_wtag),
      .arr_set_dirty (arr_set_dirty),
      .arr_clr_dirty (arr_clr_dirty),
      .rd_tag        (rd_tag),
      .rd_valid      (rd_valid),
      .rd_dirty      (rd_dirty),
      .rd_word       (rd_word),
      .rd_line       (rd_line)
   );

   banked_mem i_mem (
      .clk        (clk),
      .rst        (rst),
      .mem_rd     (mem_rd),
      .mem_wr     (mem_wr),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_stall  (mem_stall),
      .mem_rvalid (mem_rvalid),
      .mem_rdata  (mem_rdata)
   );

endmodule

/* bench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk
);

   // Half of the 10 ns period
   localparam int HALF_PERIOD = 5;

   // Free running from time zero, low first
   initial begin
      clk = 1'b0;
   end

   always begin
      #HALF_PERIOD;
      clk = ~clk;
   end

endmodule

/* bench/mem_system_assert.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_system_assert (
   input logic clk,
   input logic rst,
   input logic rd,
   input logic wr,
   input logic [`ADDR_W-1:0] addr,
   input logic done,
   input logic busy,
   input logic err,
   input logic mem_rd,
   input logic mem_wr
);

   // Failures seen so far, polled by the testbench
   int error_count = 0;

   // One-cycle done pulse
   assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else begin
         error_count = error_count + 1;
         $error("done stayed high for two cycles");
      end

   // Controller comes out of reset idle
   assert property (@(posedge clk) rst |=> !busy)
      else begin
         error_count = error_count + 1;
         $error("busy high right after reset");
      end

   // Memory port carries one kind of access at a time
   assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr))
      else begin
         error_count = error_count + 1;
         $error("mem_rd and mem_wr high together");
      end

   // err only follows a malformed strobe
   assert property (@(posedge clk) disable iff (rst)
      err |-> $past((rd || wr) && ((rd && wr) || addr[0])))
      else begin
         error_count = error_count + 1;
         $error("err without a malformed strobe in the cycle before");
      end

endmodule

bind mem_system mem_system_assert i_assert (
   .clk    (clk),
   .rst    (rst),
   .rd     (rd),
   .wr     (wr),
   .addr   (addr),
   .done   (done),
   .busy   (busy),
   .err    (err),
   .mem_rd (mem_rd),
   .mem_wr (mem_wr)
);

/* bench/mem_system_tb.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_system_tb;

   // Run budget, about 700 requests at up to 25 cycles each plus margin
   localparam int REQ_BUDGET = 700;
   localparam int WORST_REQ_CYCLES = 25;
   localparam int TIMEOUT_CYCLES = REQ_BUDGET * WORST_REQ_CYCLES + 2500;
   localparam int RAND_REQS = 600;

   logic clk;
   logic rst;
   logic rd;
   logic wr;
   logic [`ADDR_W-1:0] addr;
   mem_pkg::word_t data_in;
   mem_pkg::word_t data_out;
   logic done;
   logic hit;
   logic busy;
   logic err;

   int cycle_cnt = 0;
   int seed;

   // Reference model, flat word memory plus tag table
   mem_pkg::word_t model_mem [2**(`ADDR_W-1)];
   mem_pkg::tag_t model_tag [`LINES];
   logic model_valid [`LINES];

   // Outstanding requests, oldest first
   string exp_name_q[$];
   logic exp_rd_q[$];
   logic exp_hit_q[$];
   mem_pkg::word_t exp_data_q[$];
   int exp_cycle_q[$];

   tb_clk_gen i_clk_gen (
      .clk (clk)
   );

   mem_system i_dut (
      .clk      (clk),
      .rst      (rst),
      .rd       (rd),
      .wr       (wr),
      .addr     (addr),
      .data_in  (data_in),
      .data_out (data_out),
      .done     (done),
      .hit      (hit),
      .busy     (busy),
      .err      (err)
   );

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         stop_with_failure($sformatf("Mismatch %s expected 0x%0h actual 0x%0h",
                                     name, expected, actual));
      end
   endtask

   // Byte address from tag, line index and word offset
   function automatic logic [`ADDR_W-1:0] make_addr(input mem_pkg::tag_t t,
                                                    input mem_pkg::index_t i,
                                                    input mem_pkg::offset_t o);
      return {t, i, o, 1'b0};
   endfunction

   function automatic mem_pkg::word_t expect_read(input logic [`ADDR_W-1:0] a);
      return model_mem[a[`ADDR_W-1:1]];
   endfunction

   // Hit when the line at this index holds the same tag
   function automatic logic expect_hit(input logic [`ADDR_W-1:0] a);
      mem_pkg::index_t idx;
      idx = a[`OFFSET_W+1 +: `INDEX_W];
      return model_valid[idx] && (model_tag[idx] == a[`ADDR_W-1 -: `TAG_W]);
   endfunction

   // Any accepted request leaves its line resident
   function automatic void update_model(input logic is_wr, input logic [`ADDR_W-1:0] a,
                                        input mem_pkg::word_t d);
      mem_pkg::index_t idx;
      idx = a[`OFFSET_W+1 +: `INDEX_W];
      if (is_wr) begin
         model_mem[a[`ADDR_W-1:1]] = d;
      end
      model_valid[idx] = 1'b1;
      model_tag[idx] = a[`ADDR_W-1 -: `TAG_W];
   endfunction

   // Called on a falling edge with busy low, returns once busy drops again
   task automatic issue_req(input string name, input logic is_wr,
                            input logic [`ADDR_W-1:0] a, input mem_pkg::word_t d);
      exp_name_q.push_back(name);
      exp_rd_q.push_back(!is_wr);
      exp_hit_q.push_back(expect_hit(a));
      exp_data_q.push_back(expect_read(a));
      exp_cycle_q.push_back(cycle_cnt);
      update_model(is_wr, a, d);
      rd = !is_wr;
      wr = is_wr;
      addr = a;
      data_in = d;
      @(negedge clk);
      rd = 1'b0;
      wr = 1'b0;
      while (busy) begin
         @(negedge clk);
      end
   endtask

   // Malformed strobe, err for exactly one cycle and nothing queued
   task automatic issue_bad(input string name, input logic rd_v, input logic wr_v,
                            input logic [`ADDR_W-1:0] a, input mem_pkg::word_t d);
      rd = rd_v;
      wr = wr_v;
      addr = a;
      data_in = d;
      @(negedge clk);
      rd = 1'b0;
      wr = 1'b0;
      check_value({name, " err"}, 1, err);
      check_value({name, " busy"}, 0, busy);
      @(negedge clk);
      check_value({name, " err width"}, 0, err);
      check_value({name, " busy after"}, 0, busy);
   endtask

   // Match one done pulse against the oldest request
   task automatic compare_response();
      string name;
      logic is_rd;
      logic exp_h;
      mem_pkg::word_t exp_d;
      int issued;
      if (exp_name_q.size() == 0) begin
         stop_with_failure("done pulse seen with no request outstanding");
      end else begin
         name = exp_name_q.pop_front();
         is_rd = exp_rd_q.pop_front();
         exp_h = exp_hit_q.pop_front();
         exp_d = exp_data_q.pop_front();
         issued = exp_cycle_q.pop_front();
         check_value({name, " hit"}, exp_h, hit);
         if (is_rd) begin
            check_value({name, " data"}, exp_d, data_out);
         end
         // Hits answer in the cycle after the strobe
         if (exp_h) begin
            check_value({name, " hit latency"}, 1, cycle_cnt - issued);
         end
      end
   endtask

   // Outputs are settled by the falling edge
   always @(negedge clk) begin
      if (!rst && done) begin
         compare_response();
      end
      if (i_dut.i_assert.error_count != 0) begin
         stop_with_failure("a protocol assertion failed");
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         stop_with_failure("timeout, the run did not finish within the cycle limit");
      end
   end

   initial begin
      logic [`ADDR_W-1:0] a;
      logic [`ADDR_W-1:0] c;
      int r;
      int rd_val;
      rst = 1'b1;
      rd = 1'b0;
      wr = 1'b0;
      addr = '0;
      data_in = '0;
      seed = 40;
      for (int i = 0; i < 2**(`ADDR_W-1); i++) begin
         model_mem[i] = '0;
      end
      for (int i = 0; i < `LINES; i++) begin
         model_valid[i] = 1'b0;
         model_tag[i] = '0;
      end
      repeat (10) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      // Cold misses, then hits on the same words
      a = make_addr(5'h01, 8'h04, 2'd0);
      issue_req("cold_read", 1'b0, a, '0);
      issue_req("cold_reread", 1'b0, a, '0);
      a = make_addr(5'h02, 8'h05, 2'd3);
      issue_req("cold_read", 1'b0, a, '0);
      issue_req("cold_reread", 1'b0, a, '0);

      // Write hit, neighbours untouched
      a = make_addr(5'h01, 8'h04, 2'd1);
      issue_req("write_hit", 1'b1, a, 16'h1234);
      issue_req("write_hit_read", 1'b0, a, '0);
      for (int o = 0; o < `WORDS; o++) begin
         issue_req("write_hit_line", 1'b0, make_addr(5'h01, 8'h04, o[1:0]), '0);
      end

      // Write miss allocates the whole line
      issue_req("write_miss", 1'b1, make_addr(5'h06, 8'h30, 2'd2), 16'ha5c3);
      for (int o = 0; o < `WORDS; o++) begin
         issue_req("write_miss_line", 1'b0, make_addr(5'h06, 8'h30, o[1:0]), '0);
      end

      // Dirty line pushed out by a conflicting tag, then read back
      c = make_addr(5'h03, 8'h10, 2'd1);
      issue_req("evict_write", 1'b1, c, 16'hbeef);
      issue_req("evict_conflict", 1'b0, make_addr(5'h0b, 8'h10, 2'd0), '0);
      issue_req("evict_reread", 1'b0, c, '0);

      // Random mix over four tags and four indices
      for (int n = 0; n < RAND_REQS; n++) begin
         r = $random(seed);
         rd_val = $random(seed);
         a = make_addr({3'b000, r[1:0]}, {6'b000100, r[3:2]}, r[5:4]);
         issue_req("random", r[6], a, rd_val[15:0]);
      end

      // Malformed strobes leave cache and memory alone
      issue_bad("illegal_rdwr", 1'b1, 1'b1, c, 16'hffff);
      issue_bad("illegal_odd_wr", 1'b0, 1'b1, c | 16'h0001, 16'h5555);
      issue_bad("illegal_odd_rd", 1'b1, 1'b0, c | 16'h0001, '0);
      issue_req("illegal_after", 1'b0, c, '0);
      issue_req("illegal_after", 1'b0, make_addr(5'h06, 8'h30, 2'd2), '0);

      while (busy) begin
         @(negedge clk);
      end
      @(negedge clk);
      if (exp_name_q.size() == 0 && i_dut.i_assert.error_count == 0) begin
         $display("TB PASSED");
         $finish;
      end else begin
         stop_with_failure("requests left without done, or an assertion failed");
      end
   end

endmodule

/* sources.f */
+incdir+hdl
hdl/mem_pkg.sv
hdl/cache_array.sv
hdl/banked_mem.sv
hdl/cache_ctrl.sv
hdl/mem_system.sv
bench/tb_clk_gen.sv
bench/mem_system_assert.sv
bench/mem_system_tb.sv
